/* awg_top.f */
awg_cfg_pkg.sv
awg_ctrl_pkg.sv
awg_ctrl_if.sv
awg_regs.sv
awg_ctrl.sv
awg_sample_buffer.sv
awg_playback.sv
awg_top.sv
awg_assertions.sv
awg_tb.sv

/* awg_tb.sv */
module awg_tb import awg_cfg_pkg::*, awg_ctrl_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int depth = 256;
  localparam int sample_width = 16;
  localparam int n_rounds = 5;
  localparam time clk_period = 100;

  logic                    dma_clk;
  logic                    arst_n;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [wb_addr_w-1:0]    wb_adr;
  logic [wb_data_w-1:0]    wb_dat_w;
  logic [wb_data_w-1:0]    wb_dat_r;
  logic                    wb_ack;
  logic [sample_width-1:0] s_data;
  logic                    s_valid;
  logic                    s_last;
  logic                    s_ready;
  logic [sample_width-1:0] dac_data;
  logic                    dac_valid;
  logic                    dac_trigger;

  // reference waveform, observed output and expected output
  logic [sample_width-1:0] wave_q[$];
  logic [sample_width-1:0] out_q[$];
  logic [sample_width-1:0] exp_q[$];
  int                      trig_q[$];
  int                      exp_trig[$];
  int                      seg_cnt;
  logic                    prev_valid;
  time                     ack_time;
  time                     t_start;
  time                     first_time;
  int                      watch_limit = 0;

  awg_top #(
    .depth(depth),
    .sample_width(sample_width)
  ) i_dut (.*);

  initial begin
    dma_clk = 1'b0;
    forever #(clk_period / 2) dma_clk = ~dma_clk;
  end

  initial begin
    wait (watch_limit > 0);
    repeat (watch_limit) @(posedge dma_clk);
    $display("Timeout: the run did not finish within %0d clock cycles", watch_limit);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  // the bound checker counts its protocol violations
  always @(posedge dma_clk) begin
    if (i_dut.props_i.viol_cnt != 0) begin
      $display("A protocol assertion in the bound checker failed at t=%0t", $time);
      $display("Test failed");
      $fatal(1, "assertion failure");
    end
  end

  // output monitor that counts separate runs of dac_valid
  always @(posedge dma_clk) begin
    if (dac_valid === 1'b1) begin
      if (!prev_valid) begin
        seg_cnt++;
      end
      if (out_q.size() == 0) begin
        first_time = $time;
      end
      if (dac_trigger === 1'b1) begin
        trig_q.push_back(out_q.size());
      end
      out_q.push_back(dac_data);
    end
    prev_valid = (dac_valid === 1'b1);
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic wb_access(input logic we, input logic [wb_addr_w-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge dma_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    do begin
      @(posedge dma_clk);
    end while (wb_ack !== 1'b1);
    rdata    = wb_dat_r;
    ack_time = $time;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
  endtask

  task automatic wb_write(input logic [wb_addr_w-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [wb_addr_w-1:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'd0, data);
  endtask

  // poll the status register until the state moves on
  task automatic wait_leave(input ctrl_state_t st, output logic [31:0] status);
    do begin
      wb_read(reg_status_addr, status);
    end while (status[1:0] == st);
  endtask

  task automatic send_words(input int n, input logic with_last);
    int gap;
    logic [sample_width-1:0] d;
    for (int i = 0; i < n; i++) begin
      gap = $urandom_range(0, 2);
      d   = sample_width'($urandom);
      s_valid <= 1'b0;
      repeat (gap) @(posedge dma_clk);
      s_valid <= 1'b1;
      s_data  <= d;
      s_last  <= with_last && (i == n - 1);
      do begin
        @(posedge dma_clk);
      end while (s_ready !== 1'b1);
      wave_q.push_back(d);
    end
    s_valid <= 1'b0;
    s_last  <= 1'b0;
  endtask

  task automatic load_wave(input int last_idx, input int n, input logic with_last,
                           input logic [31:0] exp_status);
    logic [31:0] status;
    wave_q.delete();
    wb_write(reg_depth_addr, last_idx);
    wb_read(reg_depth_addr, status);
    check_eq("depth readback", status, last_idx);
    wb_write(reg_cmd_addr, 32'(op_load));
    send_words(n, with_last);
    wait_leave(st_load, status);
    check_eq("status", status, exp_status);
  endtask

  // builds the expected burst, then issues the start command
  task automatic start_burst(input int burst, input trig_mode_t mode);
    logic [31:0] rdata;
    exp_q.delete();
    exp_trig.delete();
    for (int r = 0; r < burst; r++) begin
      if (mode == trig_each_rep || (mode == trig_burst_start && r == 0)) begin
        exp_trig.push_back(exp_q.size());
      end
      foreach (wave_q[i]) begin
        exp_q.push_back(wave_q[i]);
      end
    end
    wb_write(reg_burst_addr, burst);
    wb_write(reg_trig_addr, 32'(mode));
    wb_read(reg_burst_addr, rdata);
    check_eq("burst readback", rdata, burst);
    wb_read(reg_trig_addr, rdata);
    check_eq("trigger mode readback", rdata, 32'(mode));
    out_q.delete();
    trig_q.delete();
    seg_cnt = 0;
    wb_write(reg_cmd_addr, 32'(op_start));
    t_start = ack_time;
  endtask

  task automatic play_burst(input int burst, input trig_mode_t mode);
    logic [31:0] status;
    start_burst(burst, mode);
    wait_leave(st_play, status);
    check_eq("status", status, 32'({1'b0, st_ready}));
    check_eq("dac_valid count", out_q.size(), exp_q.size());
    foreach (exp_q[k]) begin
      check_eq("dac_data", out_q[k], exp_q[k]);
    end
    check_eq("dac_trigger count", trig_q.size(), exp_trig.size());
    foreach (exp_trig[k]) begin
      check_eq("dac_trigger index", trig_q[k], exp_trig[k]);
    end
    if (burst > 0) begin
      check_eq("dac_valid runs", seg_cnt, 1);
      check_eq("dac_valid latency", 32'((first_time - t_start) / clk_period), 3);
    end
  endtask

  initial begin
    int lens[n_rounds];
    int bursts[n_rounds];
    int starts[n_rounds];
    trig_mode_t modes[n_rounds];
    int mode_ofs;
    int early_last;
    int early_n;
    int miss_last;
    int work;
    int kept;
    logic [31:0] status;

    arst_n     = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    s_data     = '0;
    s_valid    = 1'b0;
    s_last     = 1'b0;
    prev_valid = 1'b0;
    seg_cnt    = 0;
    void'($urandom(43073));

    // all random choices first, so the watchdog knows the total length
    mode_ofs = $urandom_range(0, 2);
    for (int r = 0; r < n_rounds; r++) begin
      lens[r]   = $urandom_range(0, 40);
      bursts[r] = $urandom_range(1, 3);
      modes[r]  = trig_mode_t'((mode_ofs + r) % 3);
    end
    // rounds 0, 1 and 3 play bursts in all three trigger modes
    modes[3]   = trig_mode_t'((mode_ofs + 2) % 3);
    lens[0]    = depth - 1;
    lens[4]    = $urandom_range(8, 30);
    bursts[4]  = 4;
    starts     = '{1, 3, 0, 1, 1};
    early_last = $urandom_range(2, 30);
    early_n    = $urandom_range(1, early_last);
    miss_last  = $urandom_range(0, 30);
    work = early_n + miss_last + 1;
    for (int r = 0; r < n_rounds; r++) begin
      work += (lens[r] + 1) * (1 + bursts[r] * starts[r]);
    end
    watch_limit = 4 * work + 2000;

    repeat (10) @(posedge dma_clk);
    arst_n <= 1'b1;
    @(posedge dma_clk);
    check_eq("wb_ack", wb_ack, 0);
    check_eq("s_ready", s_ready, 0);
    check_eq("dac_valid", dac_valid, 0);
    check_eq("dac_trigger", dac_trigger, 0);
    wb_read(reg_status_addr, status);
    check_eq("status", status, 32'({1'b0, st_idle}));

    // start with nothing loaded is ignored
    out_q.delete();
    wb_write(reg_cmd_addr, 32'(op_start));
    repeat (8) @(posedge dma_clk);
    check_eq("dac_valid count", out_q.size(), 0);
    wb_read(reg_status_addr, status);
    check_eq("status", status, 32'({1'b0, st_idle}));

    for (int r = 0; r < 3; r++) begin
      load_wave(lens[r], lens[r] + 1, 1'b1, 32'({1'b0, st_ready}));
      repeat (starts[r]) play_burst(bursts[r], modes[r]);
      if (starts[r] == 0) begin
        wb_write(reg_cmd_addr, 32'(op_stop));
        wb_read(reg_status_addr, status);
        check_eq("status", status, 32'({1'b0, st_idle}));
      end
    end

    // early last, then missing last
    load_wave(early_last, early_n, 1'b1, 32'({1'b1, st_idle}));
    load_wave(miss_last, miss_last + 1, 1'b0, 32'({1'b1, st_idle}));

    // recovery without reset, then an empty burst
    load_wave(lens[3], lens[3] + 1, 1'b1, 32'({1'b0, st_ready}));
    play_burst(bursts[3], modes[3]);
    play_burst(0, modes[3]);

    // stop once the first repetition is out
    load_wave(lens[4], lens[4] + 1, 1'b1, 32'({1'b0, st_ready}));
    start_burst(bursts[4], modes[4]);
    while (out_q.size() <= lens[4]) begin
      @(posedge dma_clk);
    end
    wb_write(reg_cmd_addr, 32'(op_stop));
    wb_read(reg_status_addr, status);
    check_eq("status", status, 32'({1'b0, st_idle}));
    kept = out_q.size();
    repeat (4) @(posedge dma_clk);
    check_eq("dac_valid", dac_valid, 0);
    check_eq("dac_valid count", out_q.size(), kept);
    check_eq("dac_valid early stop", kept < exp_q.size(), 1);
    for (int k = 0; k < kept; k++) begin
      check_eq("dac_data", out_q[k], exp_q[k]);
    end

    check_eq("assertion failures", i_dut.props_i.viol_cnt, 0);
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* awg_assertions.sv */
module awg_assertions import awg_ctrl_pkg::*; (
  input logic        dma_clk,
  input logic        arst_n,
  input logic        wb_cyc,
  input logic        wb_stb,
  input logic        wb_ack,
  input logic        s_ready,
  input logic        dac_valid,
  input logic        dac_trigger,
  input ctrl_state_t state
);

  timeunit 1ns;
  timeprecision 1ps;

  int viol_cnt = 0;

  // an ack answers the request seen on the previous edge
  ack_after_req: assert property (@(posedge dma_clk) disable iff (!arst_n)
    wb_ack |-> $past(wb_cyc && wb_stb))
  else begin
    viol_cnt++;
    $error("wb_ack without a preceding cyc and stb");
  end

  trig_with_valid: assert property (@(posedge dma_clk) disable iff (!arst_n)
    dac_trigger |-> dac_valid)
  else begin
    viol_cnt++;
    $error("dac_trigger without dac_valid");
  end

  // stream only accepted while loading
  ready_in_load: assert property (@(posedge dma_clk) disable iff (!arst_n)
    s_ready |-> (state == st_load))
  else begin
    viol_cnt++;
    $error("s_ready high outside st_load");
  end

endmodule

bind awg_top awg_assertions props_i (.*);

/* awg_top.sv */
module awg_top import awg_cfg_pkg::*, awg_ctrl_pkg::*; #(
  parameter int depth = 256,
  parameter int sample_width = 16,
  localparam int addr_w = $clog2(depth)
) (
  input  logic                    dma_clk,
  input  logic                    arst_n,

  // host register port
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [wb_addr_w-1:0]    wb_adr,
  input  logic [wb_data_w-1:0]    wb_dat_w,
  output logic [wb_data_w-1:0]    wb_dat_r,
  output logic                    wb_ack,

  // sample stream into the buffer
  input  logic [sample_width-1:0] s_data,
  input  logic                    s_valid,
  input  logic                    s_last,
  output logic                    s_ready,

  // real-time output, no back-pressure
  output logic [sample_width-1:0] dac_data,
  output logic                    dac_valid,
  output logic                    dac_trigger
);

  logic                    cmd_valid;
  cmd_op_t                 cmd_op;
  logic [addr_w-1:0]       depth_last;
  logic [15:0]             burst_len;
  trig_mode_t              trig_mode;
  ctrl_state_t             state;
  logic                    load_error;
  logic [addr_w-1:0]       rd_addr;
  logic [sample_width-1:0] rd_data;

  awg_ctrl_if ctl_if ();

  awg_regs #(
    .depth(depth)
  ) regs_i (
    .dma_clk, .arst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .cmd_valid, .cmd_op,
    .depth_last, .burst_len, .trig_mode,
    .state, .load_error
  );

  awg_ctrl ctrl_i (
    .dma_clk, .arst_n,
    .cmd_valid, .cmd_op,
    .state, .load_error,
    .ctl(ctl_if.ctrl)
  );

  awg_sample_buffer #(
    .depth(depth),
    .sample_width(sample_width)
  ) buffer_i (
    .dma_clk, .arst_n,
    .s_data, .s_valid, .s_last, .s_ready,
    .depth_last,
    .rd_addr, .rd_data,
    .bus(ctl_if.buffer)
  );

  awg_playback #(
    .depth(depth),
    .sample_width(sample_width)
  ) playback_i (
    .dma_clk, .arst_n,
    .depth_last, .burst_len, .trig_mode,
    .rd_addr, .rd_data,
    .dac_data, .dac_valid, .dac_trigger,
    .bus(ctl_if.playback)
  );

endmodule

/* awg_playback.sv */
module awg_playback import awg_cfg_pkg::*; #(
  parameter int depth = 256,
  parameter int sample_width = 16,
  localparam int addr_w = $clog2(depth)
) (
  input  logic                    dma_clk,
  input  logic                    arst_n,

  input  logic [addr_w-1:0]       depth_last,
  input  logic [15:0]             burst_len,
  input  trig_mode_t              trig_mode,

  output logic [addr_w-1:0]       rd_addr,
  input  logic [sample_width-1:0] rd_data,

  output logic [sample_width-1:0] dac_data,
  output logic                    dac_valid,
  output logic                    dac_trigger,

  awg_ctrl_if.playback            bus
);

  logic              run_q;
  logic [addr_w-1:0] addr_q;
  logic [addr_w-1:0] last_q;
  logic [15:0]       rep_q;
  logic [15:0]       burst_q;
  trig_mode_t        mode_q;

  logic              abort;
  logic              zero_start;
  logic              fetch;
  logic [addr_w-1:0] last_sel;
  logic [15:0]       rep_sel;
  logic [15:0]       burst_sel;
  trig_mode_t        mode_sel;
  logic              end_rep;
  logic              end_burst;
  logic              fetch_trig;

  // stage between the memory read and the output register
  logic              s1_vld;
  logic              s1_trig;
  logic              s1_done;
  logic              out_done;

  assign abort      = bus.play_start | bus.play_stop;
  assign zero_start = bus.play_start & (burst_len == 16'd0);

  // on a start the first fetch uses the live registers, later ones the latched copy
  always_comb begin
    if (bus.play_start) begin
      fetch     = (burst_len != 16'd0);
      rd_addr   = '0;
      last_sel  = depth_last;
      rep_sel   = 16'd0;
      burst_sel = burst_len;
      mode_sel  = trig_mode;
    end else begin
      fetch     = run_q & ~bus.play_stop;
      rd_addr   = addr_q;
      last_sel  = last_q;
      rep_sel   = rep_q;
      burst_sel = burst_q;
      mode_sel  = mode_q;
    end
  end

  assign end_rep    = (rd_addr == last_sel);
  assign end_burst  = end_rep && (rep_sel == burst_sel - 16'd1);
  assign fetch_trig = fetch && (rd_addr == '0) &&
                      ((mode_sel == trig_each_rep) ||
                       ((mode_sel == trig_burst_start) && (rep_sel == 16'd0)));

  always_ff @(posedge dma_clk or negedge arst_n) begin
    if (!arst_n) begin
      run_q   <= 1'b0;
      addr_q  <= '0;
      rep_q   <= '0;
      last_q  <= '0;
      burst_q <= '0;
      mode_q  <= trig_off;
    end else begin
      if (bus.play_start) begin
        last_q  <= depth_last;
        burst_q <= burst_len;
        mode_q  <= trig_mode;
      end
      if (fetch) begin
        run_q <= ~end_burst;
        if (end_rep) begin
          addr_q <= '0;
          rep_q  <= rep_sel + 16'd1;
        end else begin
          addr_q <= rd_addr + addr_w'(1);
          rep_q  <= rep_sel;
        end
      end else if (abort) begin
        run_q <= 1'b0;
      end
    end
  end

  // samples already in flight from an aborted burst are dropped here
  always_ff @(posedge dma_clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_vld        <= 1'b0;
      s1_trig       <= 1'b0;
      s1_done       <= 1'b0;
      dac_valid     <= 1'b0;
      dac_trigger   <= 1'b0;
      out_done      <= 1'b0;
      bus.play_done <= 1'b0;
    end else begin
      s1_vld        <= fetch;
      s1_trig       <= fetch_trig;
      s1_done       <= (fetch & end_burst) | zero_start;
      dac_valid     <= s1_vld & ~abort;
      dac_trigger   <= s1_trig & ~abort;
      out_done      <= s1_done & ~abort;
      // one cycle after the last sample left the output register
      bus.play_done <= out_done & ~abort;
    end
  end

  always_ff @(posedge dma_clk) begin
    if (s1_vld) begin
      dac_data <= rd_data;
    end
  end

endmodule

/* awg_sample_buffer.sv */
module awg_sample_buffer #(
  parameter int depth = 256,
  parameter int sample_width = 16,
  localparam int addr_w = $clog2(depth)
) (
  input  logic                    dma_clk,
  input  logic                    arst_n,

  input  logic [sample_width-1:0] s_data,
  input  logic                    s_valid,
  input  logic                    s_last,
  output logic                    s_ready,

  input  logic [addr_w-1:0]       depth_last,

  input  logic [addr_w-1:0]       rd_addr,
  output logic [sample_width-1:0] rd_data,

  awg_ctrl_if.buffer              bus
);

  logic [sample_width-1:0] mem [depth];

  logic              loading_q;
  logic [addr_w-1:0] wr_cnt;
  logic [addr_w-1:0] last_q;
  logic              accept;
  logic              at_end;

  // not ready in the cycle of a (re)start or an abort
  assign s_ready = loading_q & ~bus.load_en & ~bus.play_stop;
  assign accept  = s_valid & s_ready;
  assign at_end  = (wr_cnt == last_q);

  always_ff @(posedge dma_clk or negedge arst_n) begin
    if (!arst_n) begin
      loading_q     <= 1'b0;
      wr_cnt        <= '0;
      last_q        <= '0;
      bus.load_done <= 1'b0;
      bus.load_bad  <= 1'b0;
    end else begin
      // last on the final word is good
      // last early or missing on the final word is bad
      bus.load_done <= accept & s_last & at_end;
      bus.load_bad  <= accept & (s_last ^ at_end);

      if (bus.load_en) begin
        loading_q <= 1'b1;
        wr_cnt    <= '0;
        last_q    <= depth_last;
      end else if (bus.play_stop) begin
        loading_q <= 1'b0;
      end else if (accept) begin
        if (s_last || at_end) begin
          loading_q <= 1'b0;
        end else begin
          wr_cnt <= wr_cnt + addr_w'(1);
        end
      end
    end
  end

  // one write port from the stream, one registered read port for playback
  always_ff @(posedge dma_clk) begin
    if (accept) begin
      mem[wr_cnt] <= s_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

/* awg_ctrl.sv */
module awg_ctrl import awg_ctrl_pkg::*; (
  input  logic        dma_clk,
  input  logic        arst_n,

  input  logic        cmd_valid,
  input  cmd_op_t     cmd_op,

  output ctrl_state_t state,
  output logic        load_error,

  awg_ctrl_if.ctrl    ctl
);

  logic can_start;

  // a start is only meaningful once the buffer holds a good waveform
  assign can_start = (state == st_ready) || (state == st_play);

  always_ff @(posedge dma_clk or negedge arst_n) begin
    if (!arst_n) begin
      state          <= st_idle;
      load_error     <= 1'b0;
      ctl.load_en    <= 1'b0;
      ctl.play_start <= 1'b0;
      ctl.play_stop  <= 1'b0;
    end else begin
      ctl.load_en    <= 1'b0;
      ctl.play_start <= 1'b0;
      ctl.play_stop  <= 1'b0;

      // datapath events first
      case (state)
        st_load: begin
          if (ctl.load_done) begin
            state <= st_ready;
          end else if (ctl.load_bad) begin
            state      <= st_idle;
            load_error <= 1'b1;
          end
        end
        st_play: begin
          // a done from the burst being restarted must not end the new one
          if (ctl.play_done && !ctl.play_start) begin
            state <= st_ready;
          end
        end
        default: ;
      endcase

      // host commands override any event in the same cycle
      if (cmd_valid) begin
        case (cmd_op)
          op_load: begin
            state          <= st_load;
            load_error     <= 1'b0;
            ctl.load_en    <= 1'b1;
            // playback must not read while the buffer is rewritten
            ctl.play_stop  <= 1'b1;
          end
          op_start: begin
            if (can_start) begin
              state          <= st_play;
              ctl.play_start <= 1'b1;
            end
          end
          op_stop: begin
            state         <= st_idle;
            ctl.play_stop <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* awg_regs.sv */
module awg_regs import awg_cfg_pkg::*, awg_ctrl_pkg::*; #(
  parameter int depth = 256,
  localparam int addr_w = $clog2(depth)
) (
  input  logic                 dma_clk,
  input  logic                 arst_n,

  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [wb_addr_w-1:0] wb_adr,
  input  logic [wb_data_w-1:0] wb_dat_w,
  output logic [wb_data_w-1:0] wb_dat_r,
  output logic                 wb_ack,

  output logic                 cmd_valid,
  output cmd_op_t              cmd_op,

  output logic [addr_w-1:0]    depth_last,
  output logic [15:0]          burst_len,
  output trig_mode_t           trig_mode,

  input  ctrl_state_t          state,
  input  logic                 load_error
);

  logic req;
  logic wr_req;
  logic rd_req;

  // a new request while the ack is out would be the same cycle seen twice
  assign req    = wb_cyc & wb_stb & ~wb_ack;
  assign wr_req = req & wb_we;
  assign rd_req = req & ~wb_we;

  always_ff @(posedge dma_clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack     <= 1'b0;
      cmd_valid  <= 1'b0;
      cmd_op     <= op_none;
      depth_last <= '1;
      burst_len  <= 16'd1;
      trig_mode  <= trig_off;
    end else begin
      wb_ack    <= req;
      // command pulse comes out together with the ack
      cmd_valid <= wr_req && (wb_adr == reg_cmd_addr);
      if (wr_req) begin
        case (wb_adr)
          reg_cmd_addr:   cmd_op     <= cmd_op_t'(wb_dat_w[1:0]);
          reg_depth_addr: depth_last <= wb_dat_w[addr_w-1:0];
          reg_burst_addr: burst_len  <= wb_dat_w[15:0];
          reg_trig_addr:  trig_mode  <= trig_mode_t'(wb_dat_w[1:0]);
          default: ;
        endcase
      end
    end
  end

  // read data is registered so that it lines up with wb_ack
  always_ff @(posedge dma_clk) begin
    if (rd_req) begin
      case (wb_adr)
        reg_depth_addr:  wb_dat_r <= wb_data_w'(depth_last);
        reg_burst_addr:  wb_dat_r <= wb_data_w'(burst_len);
        reg_trig_addr:   wb_dat_r <= wb_data_w'(trig_mode);
        reg_status_addr: wb_dat_r <= wb_data_w'({load_error, state});
        // command register reads as zero
        default:         wb_dat_r <= '0;
      endcase
    end
  end

endmodule

/* awg_ctrl_if.sv */
interface awg_ctrl_if;

  // strobes from the controller, each one cycle wide
  logic load_en;
  logic play_start;
  logic play_stop;

  // load result from the buffer, one cycle pulses
  logic load_done;
  logic load_bad;

  // end of burst from playback
  logic play_done;

  modport ctrl (
    output load_en,
    output play_start,
    output play_stop,
    input  load_done,
    input  load_bad,
    input  play_done
  );

  // play_stop also aborts a load in progress
  modport buffer (
    input  load_en,
    input  play_stop,
    output load_done,
    output load_bad
  );

  modport playback (
    input  play_start,
    input  play_stop,
    output play_done
  );

endinterface

/* awg_ctrl_pkg.sv */
package awg_ctrl_pkg;

  // controller states, also visible in the status register
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    // buffer accepts stream words
    st_load  = 2'd1,
    // buffer holds a good waveform
    st_ready = 2'd2,
    // burst in progress
    st_play  = 2'd3
  } ctrl_state_t;

  // opcodes written to the command register
  typedef enum logic [1:0] {
    op_none  = 2'd0,
    op_load  = 2'd1,
    op_start = 2'd2,
    op_stop  = 2'd3
  } cmd_op_t;

endpackage

/* awg_cfg_pkg.sv */
package awg_cfg_pkg;

  // wishbone classic slave geometry
  // word addressed, one register per address
  localparam int wb_addr_w = 3;
  localparam int wb_data_w = 32;

  // register word addresses

  // write only, bits [1:0] carry the command opcode
  localparam logic [wb_addr_w-1:0] reg_cmd_addr    = 3'd0;

  // index of the last sample of the waveform
  localparam logic [wb_addr_w-1:0] reg_depth_addr  = 3'd1;

  // number of waveform repetitions per burst, 16 bits
  localparam logic [wb_addr_w-1:0] reg_burst_addr  = 3'd2;

  // trigger mode, bits [1:0]
  localparam logic [wb_addr_w-1:0] reg_trig_addr   = 3'd3;

  // read only, state in [1:0] and sticky load error in [2]
  localparam logic [wb_addr_w-1:0] reg_status_addr = 3'd4;

  // trigger output behavior during a burst
  // the unused encoding 2'd3 behaves like trig_off
  typedef enum logic [1:0] {
    trig_off         = 2'd0,
    // pulse with sample 0 of every repetition
    trig_each_rep    = 2'd1,
    // pulse with the first sample of the burst only
    trig_burst_start = 2'd2
  } trig_mode_t;

endpackage
